//--- l1_mempipe.f
logic/mem_pkg.sv
logic/mempipe.sv
logic/l1_tag_array.sv
logic/l1_data_array.sv
logic/fill_queue.sv
logic/load_align.sv
logic/mem_subsys_top.sv
tests/mempipe_props.sv
tests/mem_subsys_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_subsys_tb
FILELIST  = l1_mempipe.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int NUM_LOADS      = 24;
    localparam int NUM_STORES     = 24;
    localparam int NUM_OPS        = NUM_LOADS + NUM_STORES;
    localparam int LINE_W         = PADDR_W - OFFSET_W;
    localparam int NUM_LINES      = 1 << LINE_W;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 200 + 1000;

    logic                     clk;
    logic                     rst;
    logic                     ld_req;
    t_paddr                   ld_addr;
    logic [ROBID_W-1:0]       ld_robid;
    logic [PDST_W-1:0]        ld_pdst;
    logic                     ld_gnt;
    logic                     st_req;
    t_paddr                   st_addr;
    logic [ROBID_W-1:0]       st_robid;
    logic                     st_gnt;
    logic                     valid_mm5;
    t_mem_op                  op_mm5;
    t_paddr                   addr_mm5;
    logic [ROBID_W-1:0]       robid_mm5;
    logic                     complete_mm5;
    logic                     recycle_mm5;
    logic                     wr_en_mm5;
    logic [PDST_W-1:0]        wr_pdst_mm5;
    logic [LOAD_BYTES*8-1:0]  wr_data_mm5;
    logic                     miss_valid;
    logic [FLQ_IDX_W-1:0]     miss_idx;
    t_paddr                   miss_addr;
    logic                     fill_valid;
    logic [FLQ_IDX_W-1:0]     fill_idx;
    t_line                    fill_data;

    // Reference model state
    t_paddr              op_addr   [NUM_OPS];
    logic [PDST_W-1:0]   op_pdst   [NUM_OPS];
    int                  done_cnt  [NUM_OPS];
    int                  ld_q[$];
    int                  st_q[$];
    logic                line_seen [NUM_LINES];
    logic                flq_busy  [FLQ_ENTRIES];
    logic [LINE_W-1:0]   flq_line  [FLQ_ENTRIES];
    int                  flq_due   [FLQ_ENTRIES];
    logic                dl_valid  [5];
    t_mem_op             dl_op     [5];
    logic [ROBID_W-1:0]  dl_robid  [5];
    logic                ld_gnt_s;
    logic                st_gnt_s;
    int                  cycle;
    int                  completed;
    int                  mismatches;
    int                  failures;

    mem_subsys_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory content rule
    function automatic logic [7:0] mem_byte(input logic [PADDR_W-1:0] a);
        return a[7:0] ^ {a[11:8], 4'h5};
    endfunction

    function automatic t_line line_image(input logic [LINE_W-1:0] line);
        t_line img;
        for (int b = 0; b < LINE_BYTES; b++) begin
            img[8*b +: 8] = mem_byte({line, OFFSET_W'(b)});
        end
        return img;
    endfunction

    function automatic logic [LOAD_BYTES*8-1:0] load_image(input t_paddr a);
        logic [LOAD_BYTES*8-1:0] d;
        logic [OFFSET_W-1:0]     off;
        for (int i = 0; i < LOAD_BYTES; i++) begin
            off = OFFSET_W'((int'(a.f.offset) + i) % LINE_BYTES);
            d[8*i +: 8] = mem_byte({a.f.tag, a.f.set, off});
        end
        return d;
    endfunction

    function automatic logic drained();
        logic idle;
        idle = (completed == NUM_OPS);
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            if (flq_busy[e]) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic show_mismatch(input string name, input int r,
                                 input logic [63:0] got, input logic [63:0] exp);
        $display("mismatch %s robid %0d at %0t: got %h expected %h", name, r, $time, got, exp);
        mismatches++;
    endtask

    task automatic count_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        failures++;
    endtask

    // Grant to MM5 is five cycles
    task automatic check_latency();
        if (dl_valid[4]) begin
            if (!valid_mm5) begin
                count_failure($sformatf("no valid_mm5 five cycles after grant of robid %0d",
                                        dl_robid[4]));
            end else begin
                if (op_mm5 !== dl_op[4]) begin
                    show_mismatch("op_mm5", int'(dl_robid[4]), 64'(op_mm5), 64'(dl_op[4]));
                end
                if (robid_mm5 !== dl_robid[4]) begin
                    show_mismatch("robid_mm5", int'(dl_robid[4]), 64'(robid_mm5),
                                  64'(dl_robid[4]));
                end
            end
        end else if (valid_mm5 && op_mm5 != OP_FILL) begin
            count_failure("valid_mm5 for a lookup that was never granted");
        end
        for (int s = 4; s > 0; s--) begin
            dl_valid[s] = dl_valid[s-1];
            dl_op[s]    = dl_op[s-1];
            dl_robid[s] = dl_robid[s-1];
        end
        dl_valid[0] = ld_gnt || st_gnt;
        dl_op[0]    = ld_gnt ? OP_LOAD : OP_STORE;
        dl_robid[0] = ld_gnt ? ld_robid : st_robid;
    endtask

    task automatic check_result();
        int                      r;
        logic [LOAD_BYTES*8-1:0] exp;
        r = int'(robid_mm5);
        if (complete_mm5 && recycle_mm5) begin
            count_failure("complete_mm5 and recycle_mm5 high together");
        end
        if (wr_en_mm5 && !complete_mm5) begin
            count_failure("wr_en_mm5 without complete_mm5");
        end
        if (!(complete_mm5 || recycle_mm5)) begin
            return;
        end
        if (r >= NUM_OPS) begin
            count_failure($sformatf("result for robid %0d that was never issued", r));
            return;
        end
        if (addr_mm5.raw !== op_addr[r].raw) begin
            show_mismatch("addr_mm5", r, 64'(addr_mm5.raw), 64'(op_addr[r].raw));
        end
        if (recycle_mm5) begin
            if (r < NUM_LOADS) begin
                ld_q.push_back(r);
            end else begin
                st_q.push_back(r);
            end
        end
        if (complete_mm5) begin
            if (!line_seen[op_addr[r].raw[PADDR_W-1:OFFSET_W]]) begin
                count_failure($sformatf("robid %0d completed on a line never filled", r));
            end
            if (done_cnt[r] == 0) begin
                completed++;
            end else begin
                count_failure($sformatf("robid %0d completed more than once", r));
            end
            done_cnt[r]++;
            if ((r < NUM_LOADS) != wr_en_mm5) begin
                count_failure($sformatf("wr_en_mm5 wrong for completing robid %0d", r));
            end
            if (wr_en_mm5 && r < NUM_LOADS) begin
                exp = load_image(op_addr[r]);
                if (wr_data_mm5 !== exp) begin
                    show_mismatch("wr_data_mm5", r, wr_data_mm5, exp);
                end
                if (wr_pdst_mm5 !== op_pdst[r]) begin
                    show_mismatch("wr_pdst_mm5", r, 64'(wr_pdst_mm5), 64'(op_pdst[r]));
                end
            end
        end
    endtask

    task automatic track_miss();
        logic [LINE_W-1:0] line;
        line = miss_addr.raw[PADDR_W-1:OFFSET_W];
        if (flq_busy[miss_idx]) begin
            count_failure($sformatf("miss_idx %0d reused while still outstanding", miss_idx));
        end
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            if (flq_busy[e] && flq_line[e] == line) begin
                count_failure($sformatf("second miss for outstanding line %h", line));
            end
        end
        flq_busy[miss_idx] = 1'b1;
        flq_line[miss_idx] = line;
        flq_due[miss_idx]  = cycle + 2 + int'($urandom % 19);
    endtask

    task automatic drive_requests();
        if (ld_gnt_s) begin
            void'(ld_q.pop_front());
        end
        if (st_gnt_s) begin
            void'(st_q.pop_front());
        end
        ld_req <= ld_q.size() > 0;
        if (ld_q.size() > 0) begin
            ld_addr  <= op_addr[ld_q[0]];
            ld_robid <= ROBID_W'(ld_q[0]);
            ld_pdst  <= op_pdst[ld_q[0]];
        end
        st_req <= st_q.size() > 0;
        if (st_q.size() > 0) begin
            st_addr  <= op_addr[st_q[0]];
            st_robid <= ROBID_W'(st_q[0]);
        end
    endtask

    // Memory responder returns one line per cycle
    task automatic drive_fill();
        logic sent;
        sent = 1'b0;
        fill_valid <= 1'b0;
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            if (!sent && flq_busy[e] && cycle >= flq_due[e]) begin
                fill_valid <= 1'b1;
                fill_idx   <= FLQ_IDX_W'(e);
                fill_data  <= line_image(flq_line[e]);
                line_seen[flq_line[e]] = 1'b1;
                flq_busy[e] = 1'b0;
                sent = 1'b1;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        ld_gnt_s = ld_gnt;
        st_gnt_s = st_gnt;
        if (ld_gnt && st_gnt) begin
            count_failure("load and store granted in the same cycle");
        end
        check_latency();
        check_result();
        if (miss_valid) begin
            track_miss();
        end
        @(posedge clk);
        cycle++;
        drive_requests();
        drive_fill();
    endtask

    initial begin
        void'($urandom(21));
        rst        = 1'b1;
        ld_req     = 1'b0;
        ld_addr    = '0;
        ld_robid   = '0;
        ld_pdst    = '0;
        st_req     = 1'b0;
        st_addr    = '0;
        st_robid   = '0;
        fill_valid = 1'b0;
        fill_idx   = '0;
        fill_data  = '0;
        ld_gnt_s   = 1'b0;
        st_gnt_s   = 1'b0;
        cycle      = 0;
        completed  = 0;
        mismatches = 0;
        failures   = 0;
        for (int s = 0; s < 5; s++) begin
            dl_valid[s] = 1'b0;
            dl_op[s]    = OP_LOAD;
            dl_robid[s] = '0;
        end
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            flq_busy[e] = 1'b0;
            flq_line[e] = '0;
            flq_due[e]  = 0;
        end
        for (int l = 0; l < NUM_LINES; l++) begin
            line_seen[l] = 1'b0;
        end
        // Two tags per set keeps most lines resident in two ways
        for (int r = 0; r < NUM_OPS; r++) begin
            op_addr[r].raw = {TAG_W'($urandom % 2), SET_W'($urandom % NUM_SETS),
                              OFFSET_W'($urandom % LINE_BYTES)};
            op_pdst[r]  = PDST_W'($urandom % 64);
            done_cnt[r] = 0;
            if (r < NUM_LOADS) begin
                ld_q.push_back(r);
            end else begin
                st_q.push_back(r);
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (!drained()) begin
            step();
        end
        repeat (8) step();
        for (int r = 0; r < NUM_OPS; r++) begin
            if (done_cnt[r] != 1) begin
                count_failure($sformatf("robid %0d completed %0d times", r, done_cnt[r]));
            end
        end
        $display("%0d mismatches, %0d other errors, %0d of %0d operations completed",
                 mismatches, failures, completed, NUM_OPS);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the pipeline did not drain", TIMEOUT_CYCLES);
        $display("%0d mismatches, %0d other errors, %0d of %0d operations completed",
                 mismatches, failures + 1, completed, NUM_OPS);
        $display("tests failed");
        $finish;
    end

endmodule

//--- tests/mempipe_props.sv
`timescale 1ns/10ps

module mempipe_props (
    input logic clk,
    input logic rst,
    input logic ld_gnt,
    input logic st_gnt,
    input logic fl_gnt,
    input logic valid_mm5,
    input logic complete_mm5,
    input logic recycle_mm5,
    input logic flq_alloc_mm5,
    input logic wr_en_mm5
);

    // Arbiter hands out one grant at most
    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ld_gnt, st_gnt, fl_gnt}))
        else $error("more than one grant in a cycle");

    a_result_excl: assert property (@(posedge clk) disable iff (rst)
        !(complete_mm5 && recycle_mm5))
        else $error("complete_mm5 and recycle_mm5 high together");

    // Allocation only happens for a missed lookup
    a_alloc_recycle: assert property (@(posedge clk) disable iff (rst)
        flq_alloc_mm5 |-> recycle_mm5)
        else $error("flq_alloc_mm5 without recycle_mm5");

    a_reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) |->
        !(ld_gnt || st_gnt || fl_gnt || valid_mm5 || complete_mm5
          || recycle_mm5 || flq_alloc_mm5 || wr_en_mm5))
        else $error("output strobe high during reset");

endmodule

bind mempipe mempipe_props i_props (.*);

//--- logic/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              ld_req,
    input  mem_pkg::t_paddr                   ld_addr,
    input  logic [mem_pkg::ROBID_W-1:0]       ld_robid,
    input  logic [mem_pkg::PDST_W-1:0]        ld_pdst,
    output logic                              ld_gnt,
    input  logic                              st_req,
    input  mem_pkg::t_paddr                   st_addr,
    input  logic [mem_pkg::ROBID_W-1:0]       st_robid,
    output logic                              st_gnt,

    output logic                              valid_mm5,
    output mem_pkg::t_mem_op                  op_mm5,
    output mem_pkg::t_paddr                   addr_mm5,
    output logic [mem_pkg::ROBID_W-1:0]       robid_mm5,
    output logic                              complete_mm5,
    output logic                              recycle_mm5,
    output logic                              wr_en_mm5,
    output logic [mem_pkg::PDST_W-1:0]        wr_pdst_mm5,
    output logic [mem_pkg::LOAD_BYTES*8-1:0]  wr_data_mm5,

    output logic                              miss_valid,
    output logic [mem_pkg::FLQ_IDX_W-1:0]     miss_idx,
    output mem_pkg::t_paddr                   miss_addr,
    input  logic                              fill_valid,
    input  logic [mem_pkg::FLQ_IDX_W-1:0]     fill_idx,
    input  mem_pkg::t_line                    fill_data
);

    import mem_pkg::*;

    logic                      fl_req;
    logic                      fl_gnt;
    t_paddr                    fl_addr;
    t_line                     fl_line_mm1;
    logic                      rd_en_mm1;
    logic                      fill_en_mm1;
    t_paddr                    addr_mm1;
    logic [WAY_W-1:0]          fill_way;
    logic [NUM_WAYS-1:0]       tag_hit_ways_mm2;
    logic [NUM_WAYS-1:0]       hit_vec_mm2;
    logic [OFFSET_W-1:0]       offset_mm2;
    logic                      flq_match_mm2;
    t_line [NUM_WAYS-1:0]      lines_mm2;
    logic                      flq_alloc_mm5;

    mempipe i_mempipe (
        .clk, .rst,
        .ld_req, .ld_addr, .ld_robid, .ld_pdst, .ld_gnt,
        .st_req, .st_addr, .st_robid, .st_gnt,
        .fl_req, .fl_addr, .fl_gnt,
        .rd_en_mm1, .fill_en_mm1, .addr_mm1,
        .tag_hit_ways_mm2, .flq_match_mm2, .hit_vec_mm2, .offset_mm2,
        .valid_mm5, .op_mm5, .addr_mm5, .robid_mm5,
        .complete_mm5, .recycle_mm5, .flq_alloc_mm5,
        .wr_en_mm5, .wr_pdst_mm5
    );

    l1_tag_array i_tag_array (
        .clk, .rst,
        .rd_en    (rd_en_mm1),
        .fill_en  (fill_en_mm1),
        .addr     (addr_mm1),
        .hit_ways (tag_hit_ways_mm2),
        .fill_way (fill_way)
    );

    l1_data_array i_data_array (
        .clk,
        .rd_en     (rd_en_mm1),
        .fill_en   (fill_en_mm1),
        .set_idx   (addr_mm1.f.set),
        .fill_way  (fill_way),
        .fill_line (fl_line_mm1),
        .rd_lines  (lines_mm2)
    );

    load_align i_load_align (
        .clk,
        .lines_mm2, .hit_vec_mm2, .offset_mm2,
        .data_mm5 (wr_data_mm5)
    );

    fill_queue i_fill_queue (
        .clk, .rst,
        .cam_addr   (addr_mm1),
        .cam_match  (flq_match_mm2),
        .alloc      (flq_alloc_mm5),
        .alloc_addr (addr_mm5),
        .miss_valid, .miss_idx, .miss_addr,
        .fill_valid, .fill_idx, .fill_data,
        .fl_req, .fl_addr, .fl_gnt, .fl_line_mm1
    );

endmodule

//--- logic/load_align.sv
`timescale 1ns/10ps

module load_align (
    input  logic                                      clk,
    input  mem_pkg::t_line [mem_pkg::NUM_WAYS-1:0]    lines_mm2,
    input  logic [mem_pkg::NUM_WAYS-1:0]              hit_vec_mm2,
    input  logic [mem_pkg::OFFSET_W-1:0]              offset_mm2,
    output logic [mem_pkg::LOAD_BYTES*8-1:0]          data_mm5
);

    import mem_pkg::*;

    t_line                     way_line_mm2;
    t_line                     line_mm3;
    logic [OFFSET_W-1:0]       offset_mm3;
    logic [LOAD_BYTES*8-1:0]   rot_mm3;
    logic [LOAD_BYTES*8-1:0]   rot_mm4;

    // AND-OR way mux, hit vector is one-hot or zero
    always_comb begin
        way_line_mm2 = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_line_mm2 = way_line_mm2 | (lines_mm2[w] & {(LINE_BYTES*8){hit_vec_mm2[w]}});
        end
    end

    // Byte index wraps inside the line through the offset width
    always_comb begin
        logic [OFFSET_W-1:0] byte_idx;
        byte_idx = offset_mm3;
        for (int i = 0; i < LOAD_BYTES; i++) begin
            rot_mm3[8*i +: 8] = line_mm3[8*byte_idx +: 8];
            byte_idx = byte_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        line_mm3   <= way_line_mm2;
        offset_mm3 <= offset_mm2;
        rot_mm4    <= rot_mm3;
        data_mm5   <= rot_mm4;
    end

endmodule

//--- logic/fill_queue.sv
`timescale 1ns/10ps

module fill_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  mem_pkg::t_paddr                   cam_addr,
    output logic                              cam_match,
    input  logic                              alloc,
    input  mem_pkg::t_paddr                   alloc_addr,
    output logic                              miss_valid,
    output logic [mem_pkg::FLQ_IDX_W-1:0]     miss_idx,
    output mem_pkg::t_paddr                   miss_addr,
    input  logic                              fill_valid,
    input  logic [mem_pkg::FLQ_IDX_W-1:0]     fill_idx,
    input  mem_pkg::t_line                    fill_data,
    output logic                              fl_req,
    output mem_pkg::t_paddr                   fl_addr,
    input  logic                              fl_gnt,
    output mem_pkg::t_line                    fl_line_mm1
);

    import mem_pkg::*;

    // Free: ~busy, waiting: busy & ~filled, filled: busy & filled
    logic [FLQ_ENTRIES-1:0] busy;
    logic [FLQ_ENTRIES-1:0] filled;
    t_paddr                 ent_addr [FLQ_ENTRIES];
    t_line                  ent_line [FLQ_ENTRIES];

    logic                   free_found;
    logic [FLQ_IDX_W-1:0]   free_idx;
    logic [FLQ_IDX_W-1:0]   fl_sel;
    logic                   cam_hit;
    logic                   alloc_dup;
    logic                   alloc_ok;

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        fl_req     = 1'b0;
        fl_sel     = '0;
        cam_hit    = 1'b0;
        alloc_dup  = 1'b0;
        // Walk downward so the lowest index wins
        for (int e = FLQ_ENTRIES - 1; e >= 0; e--) begin
            if (!busy[e]) begin
                free_found = 1'b1;
                free_idx   = FLQ_IDX_W'(e);
            end
            if (busy[e] && filled[e]) begin
                fl_req = 1'b1;
                fl_sel = FLQ_IDX_W'(e);
            end
        end
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            if (busy[e] && ent_addr[e].raw[PADDR_W-1:OFFSET_W] ==
                    cam_addr.raw[PADDR_W-1:OFFSET_W]) begin
                cam_hit = 1'b1;
            end
            if (busy[e] && ent_addr[e].raw[PADDR_W-1:OFFSET_W] ==
                    alloc_addr.raw[PADDR_W-1:OFFSET_W]) begin
                alloc_dup = 1'b1;
            end
        end
    end

    // Full queue or a line already outstanding drops the pulse
    assign alloc_ok = alloc & free_found & ~alloc_dup;
    assign fl_addr  = ent_addr[fl_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= '0;
            filled     <= '0;
            miss_valid <= 1'b0;
        end else begin
            if (fl_gnt) begin
                busy[fl_sel]   <= 1'b0;
                filled[fl_sel] <= 1'b0;
            end
            if (fill_valid) begin
                filled[fill_idx] <= 1'b1;
            end
            if (alloc_ok) begin
                busy[free_idx] <= 1'b1;
            end
            miss_valid <= alloc_ok;
        end
    end

    always_ff @(posedge clk) begin
        cam_match <= cam_hit;
        if (alloc_ok) begin
            ent_addr[free_idx]      <= alloc_addr;
            miss_idx                <= free_idx;
            miss_addr.f.tag         <= alloc_addr.f.tag;
            miss_addr.f.set         <= alloc_addr.f.set;
            miss_addr.f.offset      <= '0;
        end
        if (fill_valid) begin
            ent_line[fill_idx] <= fill_data;
        end
        if (fl_gnt) begin
            fl_line_mm1 <= ent_line[fl_sel];
        end
    end

endmodule

//--- logic/l1_data_array.sv
`timescale 1ns/10ps

module l1_data_array (
    input  logic                                      clk,
    input  logic                                      rd_en,
    input  logic                                      fill_en,
    input  logic [mem_pkg::SET_W-1:0]                 set_idx,
    input  logic [mem_pkg::WAY_W-1:0]                 fill_way,
    input  mem_pkg::t_line                            fill_line,
    output mem_pkg::t_line [mem_pkg::NUM_WAYS-1:0]    rd_lines
);

    import mem_pkg::*;

    t_line lines [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[set_idx][fill_way] <= fill_line;
        end
    end

    // All ways read at once, way select happens after the tag compare
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_lines[w] <= lines[set_idx][w];
            end
        end
    end

endmodule

//--- logic/l1_tag_array.sv
`timescale 1ns/10ps

module l1_tag_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_en,
    input  logic                          fill_en,
    input  mem_pkg::t_paddr               addr,
    output logic [mem_pkg::NUM_WAYS-1:0]  hit_ways,
    output logic [mem_pkg::WAY_W-1:0]     fill_way
);

    import mem_pkg::*;

    logic [TAG_W-1:0]    tags      [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] way_valid [NUM_SETS];
    logic [WAY_W-1:0]    rr_ptr    [NUM_SETS];

    // Victim way for this set, shared with the data array
    assign fill_way = rr_ptr[addr.f.set];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                way_valid[s] <= '0;
                rr_ptr[s]    <= '0;
            end
        end else if (fill_en) begin
            way_valid[addr.f.set][fill_way] <= 1'b1;
            if (fill_way == WAY_W'(NUM_WAYS - 1)) begin
                rr_ptr[addr.f.set] <= '0;
            end else begin
                rr_ptr[addr.f.set] <= fill_way + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[addr.f.set][fill_way] <= addr.f.tag;
        end
    end

    // Match registered so it lands in MM2
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                hit_ways[w] <= way_valid[addr.f.set][w]
                             & (tags[addr.f.set][w] == addr.f.tag);
            end
        end
    end

endmodule

//--- logic/mempipe.sv
`timescale 1ns/10ps

module mempipe (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              ld_req,
    input  mem_pkg::t_paddr                   ld_addr,
    input  logic [mem_pkg::ROBID_W-1:0]       ld_robid,
    input  logic [mem_pkg::PDST_W-1:0]        ld_pdst,
    output logic                              ld_gnt,

    input  logic                              st_req,
    input  mem_pkg::t_paddr                   st_addr,
    input  logic [mem_pkg::ROBID_W-1:0]       st_robid,
    output logic                              st_gnt,

    input  logic                              fl_req,
    input  mem_pkg::t_paddr                   fl_addr,
    output logic                              fl_gnt,

    output logic                              rd_en_mm1,
    output logic                              fill_en_mm1,
    output mem_pkg::t_paddr                   addr_mm1,

    input  logic [mem_pkg::NUM_WAYS-1:0]      tag_hit_ways_mm2,
    input  logic                              flq_match_mm2,
    output logic [mem_pkg::NUM_WAYS-1:0]      hit_vec_mm2,
    output logic [mem_pkg::OFFSET_W-1:0]      offset_mm2,

    output logic                              valid_mm5,
    output mem_pkg::t_mem_op                  op_mm5,
    output mem_pkg::t_paddr                   addr_mm5,
    output logic [mem_pkg::ROBID_W-1:0]       robid_mm5,
    output logic                              complete_mm5,
    output logic                              recycle_mm5,
    output logic                              flq_alloc_mm5,
    output logic                              wr_en_mm5,
    output logic [mem_pkg::PDST_W-1:0]        wr_pdst_mm5
);

    import mem_pkg::*;

    logic                valid_mm0;
    t_mem_op             op_mm0;
    t_paddr              addr_mm0;
    logic [ROBID_W-1:0]  robid_mm0;
    logic [PDST_W-1:0]   pdst_mm0;

    // Stage registers, index is the stage number
    logic [5:1]          valid_q;
    t_mem_op             op_q    [1:5];
    t_paddr              addr_q  [1:5];
    logic [ROBID_W-1:0]  robid_q [1:5];
    logic [PDST_W-1:0]   pdst_q  [1:5];
    logic [5:3]          hit_q;
    logic [5:3]          match_q;

    logic                lookup_mm2;
    logic                lookup_mm5;

    // MM0 fixed priority: fill, load, store
    assign fl_gnt = fl_req;
    assign ld_gnt = ld_req & ~fl_req;
    assign st_gnt = st_req & ~fl_req & ~ld_req;
    assign valid_mm0 = fl_gnt | ld_gnt | st_gnt;

    always_comb begin
        op_mm0    = OP_LOAD;
        addr_mm0  = ld_addr;
        robid_mm0 = ld_robid;
        pdst_mm0  = ld_pdst;
        if (fl_gnt) begin
            op_mm0    = OP_FILL;
            addr_mm0  = fl_addr;
            robid_mm0 = '0;
            pdst_mm0  = '0;
        end else if (st_gnt) begin
            op_mm0    = OP_STORE;
            addr_mm0  = st_addr;
            robid_mm0 = st_robid;
            pdst_mm0  = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[4:1], valid_mm0};
        end
    end

    always_ff @(posedge clk) begin
        op_q[1]    <= op_mm0;
        addr_q[1]  <= addr_mm0;
        robid_q[1] <= robid_mm0;
        pdst_q[1]  <= pdst_mm0;
        for (int s = 2; s <= 5; s++) begin
            op_q[s]    <= op_q[s-1];
            addr_q[s]  <= addr_q[s-1];
            robid_q[s] <= robid_q[s-1];
            pdst_q[s]  <= pdst_q[s-1];
        end
        hit_q   <= {hit_q[4:3], |hit_vec_mm2};
        match_q <= {match_q[4:3], flq_match_mm2};
    end

    // MM1 array access
    assign rd_en_mm1   = valid_q[1] & (op_q[1] == OP_LOAD || op_q[1] == OP_STORE);
    assign fill_en_mm1 = valid_q[1] & (op_q[1] == OP_FILL);
    assign addr_mm1    = addr_q[1];

    // MM2 hit qualify; fills never hit
    assign lookup_mm2  = valid_q[2] & (op_q[2] == OP_LOAD || op_q[2] == OP_STORE);
    assign hit_vec_mm2 = tag_hit_ways_mm2 & {NUM_WAYS{lookup_mm2}};
    assign offset_mm2  = addr_q[2].f.offset;

    // MM5 result
    assign lookup_mm5    = valid_q[5] & (op_q[5] == OP_LOAD || op_q[5] == OP_STORE);
    assign valid_mm5     = valid_q[5];
    assign op_mm5        = op_q[5];
    assign addr_mm5      = addr_q[5];
    assign robid_mm5     = robid_q[5];
    assign complete_mm5  = lookup_mm5 & hit_q[5];
    assign recycle_mm5   = lookup_mm5 & ~hit_q[5];
    // Miss already in flight just recycles
    assign flq_alloc_mm5 = recycle_mm5 & ~match_q[5];
    assign wr_en_mm5     = complete_mm5 & (op_q[5] == OP_LOAD);
    assign wr_pdst_mm5   = pdst_q[5];

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    // Cache geometry
    localparam int NUM_WAYS   = 2;
    localparam int WAY_W      = 1;
    localparam int NUM_SETS   = 16;
    localparam int LINE_BYTES = 32;

    // Physical address split
    localparam int OFFSET_W = 5;
    localparam int SET_W    = 4;
    localparam int TAG_W    = 3;
    localparam int PADDR_W  = TAG_W + SET_W + OFFSET_W;

    // Outstanding misses
    localparam int FLQ_ENTRIES = 4;
    localparam int FLQ_IDX_W   = 2;

    localparam int ROBID_W    = 6;
    localparam int PDST_W     = 6;
    localparam int LOAD_BYTES = 8;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FILL  = 2'd2
    } t_mem_op;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    set;
        logic [OFFSET_W-1:0] offset;
    } t_paddr_fields;

    // Raw word for requesters and the CAM, fields for the arrays
    typedef union packed {
        logic [PADDR_W-1:0] raw;
        t_paddr_fields      f;
    } t_paddr;

    typedef logic [LINE_BYTES*8-1:0] t_line;

endpackage
